// File: hdl/exu_pkg.sv
package exu_pkg;

  localparam int XLEN       = 32;
  localparam int MEM_DATA_W = 64;
  localparam int MEM_STRB_W = MEM_DATA_W / 8;

  // follows rv32 funct3 order
  typedef enum logic [2:0] {
    alu_add,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_or,
    alu_and
  } alu_op_t;

  typedef enum logic [3:0] {
    ls_none,
    ls_lb,
    ls_lh,
    ls_lw,
    ls_lbu,
    ls_lhu,
    ls_sb,
    ls_sh,
    ls_sw
  } ls_op_t;

  typedef enum logic [2:0] {
    br_none,
    br_nz,   // alu result nonzero
    br_z,    // alu result zero
    br_jal,
    br_jalr,
    br_jr
  } branch_t;

  typedef enum logic [1:0] {seq_idle, seq_busy, seq_hold} seq_state_t;

  typedef enum logic [2:0] {
    lsu_idle,
    lsu_rd_req,
    lsu_rd_resp,
    lsu_wr_req,
    lsu_wr_addr,   // data taken, address still pending
    lsu_wr_data,   // address taken, data still pending
    lsu_wr_resp
  } lsu_state_t;

  function automatic logic is_load(ls_op_t op);
    return op inside {ls_lb, ls_lh, ls_lw, ls_lbu, ls_lhu};
  endfunction

  function automatic logic is_store(ls_op_t op);
    return op inside {ls_sb, ls_sh, ls_sw};
  endfunction

endpackage

// File: hdl/exu_alu.sv
`timescale 1ns/1ps

module exu_alu (
  input  logic [exu_pkg::XLEN-1:0] pc,
  input  logic [exu_pkg::XLEN-1:0] a,
  input  logic [exu_pkg::XLEN-1:0] b,
  input  logic                     use_pc,
  input  logic                     alt,
  input  exu_pkg::alu_op_t         op,
  output logic [exu_pkg::XLEN-1:0] result
);
  import exu_pkg::*;

  logic [XLEN-1:0] opa;
  logic [4:0]      shamt;

  assign opa   = use_pc ? pc : a; // auipc / jal style
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add:  result = alt ? (opa - b) : (opa + b);
      alu_sll:  result = opa << shamt;
      alu_slt:  result = {{(XLEN-1){1'b0}}, $signed(opa) < $signed(b)};
      alu_sltu: result = {{(XLEN-1){1'b0}}, opa < b};
      alu_xor:  result = opa ^ b;
      alu_srl: begin
        if (alt) begin
          result = $unsigned($signed(opa) >>> shamt); // sra
        end else begin
          result = opa >> shamt;
        end
      end
      alu_or:   result = opa | b;
      alu_and:  result = opa & b;
      default:  result = '0;
    endcase
  end

endmodule

// File: hdl/exu_lsu.sv
`timescale 1ns/1ps

module exu_lsu (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           start,
  input  exu_pkg::ls_op_t                op,
  input  logic [exu_pkg::XLEN-1:0]       addr,
  input  logic [exu_pkg::XLEN-1:0]       store_data,
  output logic                           done,
  output logic [exu_pkg::XLEN-1:0]       load_data,

  output logic                           mem_ar_valid,
  input  logic                           mem_ar_ready,
  output logic [exu_pkg::XLEN-1:0]       mem_ar_addr,
  input  logic                           mem_r_valid,
  output logic                           mem_r_ready,
  input  logic [exu_pkg::MEM_DATA_W-1:0] mem_r_data,

  output logic                           mem_aw_valid,
  input  logic                           mem_aw_ready,
  output logic [exu_pkg::XLEN-1:0]       mem_aw_addr,
  output logic                           mem_w_valid,
  input  logic                           mem_w_ready,
  output logic [exu_pkg::MEM_DATA_W-1:0] mem_w_data,
  output logic [exu_pkg::MEM_STRB_W-1:0] mem_w_strb,
  input  logic                           mem_b_valid,
  output logic                           mem_b_ready
);
  import exu_pkg::*;

  lsu_state_t            state, state_next;
  ls_op_t                op_q;
  logic [XLEN-1:0]       data_q;
  logic [5:0]            lane_shift;
  logic [MEM_STRB_W-1:0] strb_base;
  logic [MEM_DATA_W-1:0] beat;
  logic [XLEN-1:0]       load_ext;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= lsu_idle;
    end else begin
      state <= state_next;
    end
  end

  // op and store data only arrive with the start pulse
  always_ff @(posedge clock) begin
    if (start) begin
      op_q   <= op;
      data_q <= store_data;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      lsu_idle: begin
        if (start && is_load(op)) begin
          state_next = lsu_rd_req;
        end else if (start && is_store(op)) begin
          state_next = lsu_wr_req;
        end
      end
      lsu_rd_req:  if (mem_ar_ready) state_next = lsu_rd_resp;
      lsu_rd_resp: if (mem_r_valid) state_next = lsu_idle;
      lsu_wr_req: begin
        if (mem_aw_ready && mem_w_ready) begin
          state_next = lsu_wr_resp;
        end else if (mem_aw_ready) begin
          state_next = lsu_wr_data;
        end else if (mem_w_ready) begin
          state_next = lsu_wr_addr;
        end
      end
      lsu_wr_addr: if (mem_aw_ready) state_next = lsu_wr_resp;
      lsu_wr_data: if (mem_w_ready) state_next = lsu_wr_resp;
      lsu_wr_resp: if (mem_b_valid) state_next = lsu_idle;
      default:     state_next = lsu_idle;
    endcase
  end

  assign mem_ar_valid = (state == lsu_rd_req);
  assign mem_ar_addr  = addr;
  assign mem_r_ready  = (state == lsu_rd_resp);
  assign mem_aw_valid = (state == lsu_wr_req) || (state == lsu_wr_addr);
  assign mem_aw_addr  = addr;
  assign mem_w_valid  = (state == lsu_wr_req) || (state == lsu_wr_data);
  assign mem_b_ready  = (state == lsu_wr_resp);

  assign done = (mem_r_valid && mem_r_ready) || (mem_b_valid && mem_b_ready);

  assign lane_shift = {addr[2:0], 3'b000}; // byte lane in bits

  // store side
  always_comb begin
    case (op_q)
      ls_sb:   strb_base = 8'h01;
      ls_sh:   strb_base = 8'h03;
      ls_sw:   strb_base = 8'h0f;
      default: strb_base = 8'h00;
    endcase
  end

  assign mem_w_data = {{(MEM_DATA_W-XLEN){1'b0}}, data_q} << lane_shift;
  assign mem_w_strb = strb_base << addr[2:0];

  // load side
  assign beat = mem_r_data >> lane_shift;

  always_comb begin
    case (op_q)
      ls_lb:   load_ext = {{24{beat[7]}}, beat[7:0]};
      ls_lh:   load_ext = {{16{beat[15]}}, beat[15:0]};
      ls_lbu:  load_ext = {24'b0, beat[7:0]};
      ls_lhu:  load_ext = {16'b0, beat[15:0]};
      default: load_ext = beat[XLEN-1:0]; // lw
    endcase
  end

  always_ff @(posedge clock) begin
    if (mem_r_valid && mem_r_ready) begin
      load_data <= load_ext;
    end
  end

endmodule

// File: hdl/exu_sequencer.sv
`timescale 1ns/1ps

module exu_sequencer (
  input  logic                     clock,
  input  logic                     reset,

  input  logic                     in_valid,
  output logic                     in_ready,
  input  logic [exu_pkg::XLEN-1:0] in_pc,
  input  logic [exu_pkg::XLEN-1:0] in_a,
  input  logic [exu_pkg::XLEN-1:0] in_b,
  input  logic [exu_pkg::XLEN-1:0] in_c,
  input  logic                     in_use_pc,
  input  exu_pkg::alu_op_t         in_alu_op,
  input  logic                     in_alu_alt,
  input  logic [4:0]               in_rd,
  input  logic                     in_rd_from_a,
  input  exu_pkg::ls_op_t          in_ls_op,
  input  exu_pkg::branch_t         in_branch,

  output logic                     out_valid,
  input  logic                     out_ready,
  output logic                     out_rd_wen,
  output logic [4:0]               out_rd_addr,
  output logic [exu_pkg::XLEN-1:0] out_rd_data,

  output logic                     redirect,
  output logic [exu_pkg::XLEN-1:0] redirect_pc,
  output logic [4:0]               busy_rd,

  output logic [exu_pkg::XLEN-1:0] alu_pc,
  output logic [exu_pkg::XLEN-1:0] alu_a,
  output logic [exu_pkg::XLEN-1:0] alu_b,
  output logic                     alu_use_pc,
  output logic                     alu_alt,
  output exu_pkg::alu_op_t         alu_op,
  input  logic [exu_pkg::XLEN-1:0] alu_result,

  output logic                     lsu_start,
  output exu_pkg::ls_op_t          lsu_op,
  output logic [exu_pkg::XLEN-1:0] lsu_store_data,
  input  logic                     lsu_done,
  input  logic [exu_pkg::XLEN-1:0] lsu_load_data
);
  import exu_pkg::*;

  seq_state_t      state, state_next;
  logic            accept;

  logic [XLEN-1:0] pc_q, a_q, b_q, c_q;
  logic            use_pc_q, alt_q, rd_from_a_q;
  alu_op_t         alu_op_q;
  logic [4:0]      rd_q;
  ls_op_t          ls_op_q;
  branch_t         branch_q;

  logic            taken;
  logic [XLEN-1:0] target;

  assign in_ready = (state == seq_idle) || (state == seq_hold && out_ready);
  assign accept   = in_valid && in_ready;

  always_comb begin
    state_next = state;
    if (accept) begin
      state_next = (in_ls_op == ls_none) ? seq_hold : seq_busy;
    end else begin
      case (state)
        seq_busy: if (lsu_done) state_next = seq_hold;
        seq_hold: if (out_ready) state_next = seq_idle;
        default:  ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= seq_idle;
      rd_q     <= '0;
      ls_op_q  <= ls_none;
      branch_q <= br_none;
    end else begin
      state <= state_next;
      if (accept) begin
        rd_q     <= in_rd;
        ls_op_q  <= in_ls_op;
        branch_q <= in_branch;
      end
    end
  end

  // operand payload
  always_ff @(posedge clock) begin
    if (accept) begin
      pc_q        <= in_pc;
      a_q         <= in_a;
      b_q         <= in_b;
      c_q         <= in_c;
      use_pc_q    <= in_use_pc;
      alu_op_q    <= in_alu_op;
      alt_q       <= in_alu_alt;
      rd_from_a_q <= in_rd_from_a;
    end
  end

  assign alu_pc     = pc_q;
  assign alu_a      = a_q;
  assign alu_b      = b_q;
  assign alu_use_pc = use_pc_q;
  assign alu_alt    = alt_q;
  assign alu_op     = alu_op_q;

  // lsu latches op and data on this pulse so the request goes out next cycle
  assign lsu_start      = accept && (in_ls_op != ls_none);
  assign lsu_op         = in_ls_op;
  assign lsu_store_data = in_c;

  assign out_valid   = (state == seq_hold);
  assign out_rd_wen  = (rd_q != 5'd0) && !is_store(ls_op_q);
  assign out_rd_addr = rd_q;

  always_comb begin
    if (is_load(ls_op_q)) begin
      out_rd_data = lsu_load_data;
    end else if (rd_from_a_q) begin
      out_rd_data = a_q; // link value
    end else begin
      out_rd_data = alu_result;
    end
  end

  always_comb begin
    case (branch_q)
      br_nz:   taken = |alu_result;
      br_z:    taken = ~|alu_result;
      br_jal,
      br_jalr,
      br_jr:   taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (branch_q)
      br_jalr: target = a_q + c_q;
      br_jr:   target = a_q;
      default: target = pc_q + c_q; // conditional branches and jal
    endcase
  end

  // no prediction, so every taken branch redirects
  assign redirect    = out_valid && taken;
  assign redirect_pc = {target[XLEN-1:1], 1'b0};

  assign busy_rd = (state == seq_idle) ? 5'd0 : rd_q;

endmodule

// File: hdl/exu_top.sv
`timescale 1ns/1ps

module exu_top (
  input  logic                           clock,
  input  logic                           reset,

  input  logic                           in_valid,
  output logic                           in_ready,
  input  logic [exu_pkg::XLEN-1:0]       in_pc,
  input  logic [exu_pkg::XLEN-1:0]       in_a,
  input  logic [exu_pkg::XLEN-1:0]       in_b,
  input  logic [exu_pkg::XLEN-1:0]       in_c,
  input  logic                           in_use_pc,
  input  exu_pkg::alu_op_t               in_alu_op,
  input  logic                           in_alu_alt,
  input  logic [4:0]                     in_rd,
  input  logic                           in_rd_from_a,
  input  exu_pkg::ls_op_t                in_ls_op,
  input  exu_pkg::branch_t               in_branch,

  output logic                           out_valid,
  input  logic                           out_ready,
  output logic                           out_rd_wen,
  output logic [4:0]                     out_rd_addr,
  output logic [exu_pkg::XLEN-1:0]       out_rd_data,

  output logic                           redirect,
  output logic [exu_pkg::XLEN-1:0]       redirect_pc,
  output logic [4:0]                     busy_rd,

  output logic                           mem_ar_valid,
  input  logic                           mem_ar_ready,
  output logic [exu_pkg::XLEN-1:0]       mem_ar_addr,
  input  logic                           mem_r_valid,
  output logic                           mem_r_ready,
  input  logic [exu_pkg::MEM_DATA_W-1:0] mem_r_data,
  output logic                           mem_aw_valid,
  input  logic                           mem_aw_ready,
  output logic [exu_pkg::XLEN-1:0]       mem_aw_addr,
  output logic                           mem_w_valid,
  input  logic                           mem_w_ready,
  output logic [exu_pkg::MEM_DATA_W-1:0] mem_w_data,
  output logic [exu_pkg::MEM_STRB_W-1:0] mem_w_strb,
  input  logic                           mem_b_valid,
  output logic                           mem_b_ready
);
  import exu_pkg::*;

  logic [XLEN-1:0] alu_pc, alu_a, alu_b, alu_result;
  logic            alu_use_pc, alu_alt;
  alu_op_t         alu_op;

  logic            lsu_start, lsu_done;
  ls_op_t          lsu_op;
  logic [XLEN-1:0] lsu_store_data, lsu_load_data;

  exu_sequencer u_sequencer (
    .clock, .reset,
    .in_valid, .in_ready, .in_pc, .in_a, .in_b, .in_c, .in_use_pc,
    .in_alu_op, .in_alu_alt, .in_rd, .in_rd_from_a, .in_ls_op, .in_branch,
    .out_valid, .out_ready, .out_rd_wen, .out_rd_addr, .out_rd_data,
    .redirect, .redirect_pc, .busy_rd,
    .alu_pc, .alu_a, .alu_b, .alu_use_pc, .alu_alt, .alu_op, .alu_result,
    .lsu_start, .lsu_op, .lsu_store_data, .lsu_done, .lsu_load_data
  );

  exu_alu u_alu (
    .pc     (alu_pc),
    .a      (alu_a),
    .b      (alu_b),
    .use_pc (alu_use_pc),
    .alt    (alu_alt),
    .op     (alu_op),
    .result (alu_result)
  );

  // alu result doubles as the memory address
  exu_lsu u_lsu (
    .clock, .reset,
    .start      (lsu_start),
    .op         (lsu_op),
    .addr       (alu_result),
    .store_data (lsu_store_data),
    .done       (lsu_done),
    .load_data  (lsu_load_data),
    .mem_ar_valid, .mem_ar_ready, .mem_ar_addr,
    .mem_r_valid, .mem_r_ready, .mem_r_data,
    .mem_aw_valid, .mem_aw_ready, .mem_aw_addr,
    .mem_w_valid, .mem_w_ready, .mem_w_data, .mem_w_strb,
    .mem_b_valid, .mem_b_ready
  );

endmodule

// File: bench/exu_mem_model.sv
`timescale 1ns/1ps

module exu_mem_model (
  input  logic                           clock,
  input  logic                           reset,
  input  logic [31:0]                    mem_rnd,   // fresh random bits every cycle

  input  logic                           mem_ar_valid,
  output logic                           mem_ar_ready,
  input  logic [exu_pkg::XLEN-1:0]       mem_ar_addr,
  output logic                           mem_r_valid,
  input  logic                           mem_r_ready,
  output logic [exu_pkg::MEM_DATA_W-1:0] mem_r_data,
  input  logic                           mem_aw_valid,
  output logic                           mem_aw_ready,
  input  logic [exu_pkg::XLEN-1:0]       mem_aw_addr,
  input  logic                           mem_w_valid,
  output logic                           mem_w_ready,
  input  logic [exu_pkg::MEM_DATA_W-1:0] mem_w_data,
  input  logic [exu_pkg::MEM_STRB_W-1:0] mem_w_strb,
  output logic                           mem_b_valid,
  input  logic                           mem_b_ready
);
  import exu_pkg::*;

  logic [MEM_DATA_W-1:0] mem [0:31]; // 256 bytes, indexed by addr[7:3]

  logic                  rd_pend   = 1'b0;
  logic                  r_valid_q = 1'b0;
  logic                  aw_got    = 1'b0;
  logic                  w_got     = 1'b0;
  logic                  b_valid_q = 1'b0;
  logic [XLEN-1:0]       rd_addr   = '0;
  logic [XLEN-1:0]       wr_addr   = '0;
  logic [MEM_DATA_W-1:0] wr_data   = '0;
  logic [MEM_STRB_W-1:0] wr_strb   = '0;

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i / 8][8 * (i % 8) +: 8] = 8'(i * 8'h9d + 8'h3b);
    end
  end

  assign mem_ar_ready = !rd_pend && mem_rnd[0];
  assign mem_r_valid  = r_valid_q;
  assign mem_r_data   = mem[rd_addr[7:3]];
  assign mem_aw_ready = !aw_got && mem_rnd[1];
  assign mem_w_ready  = !w_got && mem_rnd[2];
  assign mem_b_valid  = b_valid_q;

  always @(posedge clock) begin
    if (reset) begin
      rd_pend   <= 1'b0;
      r_valid_q <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      if (mem_ar_valid && mem_ar_ready) begin
        rd_pend <= 1'b1;
        rd_addr <= mem_ar_addr;
      end
      if (rd_pend && !r_valid_q && mem_rnd[3]) r_valid_q <= 1'b1; // random read latency
      if (mem_r_valid && mem_r_ready) begin
        r_valid_q <= 1'b0;
        rd_pend   <= 1'b0;
      end
      if (mem_aw_valid && mem_aw_ready) begin
        aw_got  <= 1'b1;
        wr_addr <= mem_aw_addr;
      end
      if (mem_w_valid && mem_w_ready) begin
        w_got   <= 1'b1;
        wr_data <= mem_w_data;
        wr_strb <= mem_w_strb;
      end
      // commit once both halves are in
      if (aw_got && w_got && !b_valid_q && mem_rnd[4]) begin
        for (int i = 0; i < MEM_STRB_W; i++) begin
          if (wr_strb[i]) mem[wr_addr[7:3]][8 * i +: 8] <= wr_data[8 * i +: 8];
        end
        b_valid_q <= 1'b1;
      end
      if (mem_b_valid && mem_b_ready) begin
        b_valid_q <= 1'b0;
        aw_got    <= 1'b0;
        w_got     <= 1'b0;
      end
    end
  end

endmodule

// File: bench/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;
  import exu_pkg::*;

  typedef struct packed {
    logic            wen;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
    logic            redirect;
    logic [XLEN-1:0] target;
  } wb_exp_t;

  logic                  clock = 1'b0;
  logic                  reset = 1'b1;
  logic                  in_valid, in_ready;
  logic [XLEN-1:0]       in_pc, in_a, in_b, in_c;
  logic                  in_use_pc, in_alu_alt, in_rd_from_a;
  alu_op_t               in_alu_op;
  logic [4:0]            in_rd;
  ls_op_t                in_ls_op;
  branch_t               in_branch;
  logic                  out_valid, out_rd_wen;
  logic                  out_ready = 1'b1;
  logic [4:0]            out_rd_addr, busy_rd;
  logic [XLEN-1:0]       out_rd_data, redirect_pc;
  logic                  redirect;
  logic                  mem_ar_valid, mem_ar_ready, mem_r_valid, mem_r_ready;
  logic                  mem_aw_valid, mem_aw_ready, mem_w_valid, mem_w_ready;
  logic                  mem_b_valid, mem_b_ready;
  logic [XLEN-1:0]       mem_ar_addr, mem_aw_addr;
  logic [MEM_DATA_W-1:0] mem_r_data, mem_w_data;
  logic [MEM_STRB_W-1:0] mem_w_strb;
  logic [31:0]           mem_rnd = '0;

  logic [7:0]  shadow [0:255];
  wb_exp_t     exp_q [$];
  ls_op_t      store_ops [3] = '{ls_sb, ls_sh, ls_sw};
  ls_op_t      load_ops [5]  = '{ls_lb, ls_lh, ls_lw, ls_lbu, ls_lhu};
  logic [31:0] rng_stim = 32'h60cf_2c30;
  logic [31:0] rng_mem  = ~32'h60cf_2c30; // separate stream for the memory side
  logic        bp_mode  = 1'b0;
  logic [2:0]  stretch  = '0;
  logic        held     = 1'b0;
  logic [70:0] held_snap;
  int          n_issued = 0;
  int          n_pass   = 0;
  int          n_fail   = 0;
  int          cycles   = 0;
  int          test_issued, test_fail;
  string       cur_test = "reset";

  always #10 clock = ~clock;

  exu_top u_exu_top (.*);
  exu_mem_model u_mem (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] stim_rand();
    rng_stim = xorshift(rng_stim);
    return rng_stim;
  endfunction

  function automatic int ls_bytes(input ls_op_t ls);
    case (ls)
      ls_sb, ls_lb, ls_lbu: return 1;
      ls_sh, ls_lh, ls_lhu: return 2;
      default:              return 4;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] alu_ref(input logic [XLEN-1:0] pc, a, b,
                                              input logic use_pc, alt, input alu_op_t op);
    logic [XLEN-1:0] x;
    logic [XLEN-1:0] r;
    logic [4:0]      sh;
    x  = use_pc ? pc : a;
    sh = b[4:0];
    case (op)
      alu_add:  r = alt ? x + ~b + 32'd1 : x + b;
      alu_sll:  r = x << sh;
      alu_slt:  r = ($signed(x) < $signed(b)) ? 32'd1 : 32'd0;
      alu_sltu: r = (x < b) ? 32'd1 : 32'd0;
      alu_xor:  r = x ^ b;
      alu_or:   r = x | b;
      alu_and:  r = x & b;
      default: begin
        if (alt) r = $signed(x) >>> sh;
        else r = x >> sh;
      end
    endcase
    return r;
  endfunction

  function automatic logic [XLEN-1:0] load_ref(input ls_op_t ls, input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] w;
    for (int i = 0; i < 4; i++) w[8 * i +: 8] = shadow[8'(addr + i)]; // little endian
    case (ls)
      ls_lb:   return {{24{w[7]}}, w[7:0]};
      ls_lh:   return {{16{w[15]}}, w[15:0]};
      ls_lbu:  return {24'b0, w[7:0]};
      ls_lhu:  return {16'b0, w[15:0]};
      default: return w;
    endcase
  endfunction

  function automatic wb_exp_t ref_exec(input logic [XLEN-1:0] pc, a, b, c,
                                       input logic use_pc, input alu_op_t op,
                                       input logic alt, input logic [4:0] rd,
                                       input logic rd_from_a, input ls_op_t ls,
                                       input branch_t br);
    wb_exp_t         e;
    logic [XLEN-1:0] res, tgt;
    res   = alu_ref(pc, a, b, use_pc, alt, op);
    e.rd  = rd;
    e.wen = (rd != 5'd0) && !(ls inside {ls_sb, ls_sh, ls_sw});
    if (ls inside {ls_lb, ls_lh, ls_lw, ls_lbu, ls_lhu}) e.data = load_ref(ls, res);
    else if (rd_from_a) e.data = a;
    else e.data = res;
    case (br)
      br_nz:                  e.redirect = (res != '0);
      br_z:                   e.redirect = (res == '0);
      br_jal, br_jalr, br_jr: e.redirect = 1'b1;
      default:                e.redirect = 1'b0;
    endcase
    case (br)
      br_jalr: tgt = a + c;
      br_jr:   tgt = a;
      default: tgt = pc + c;
    endcase
    e.target = {tgt[XLEN-1:1], 1'b0};
    return e;
  endfunction

  task automatic shadow_write(input ls_op_t ls, input logic [XLEN-1:0] addr, data);
    for (int i = 0; i < ls_bytes(ls); i++) shadow[8'(addr + i)] = data[8 * i +: 8];
  endtask

  task automatic tally(input logic ok, input string field,
                       input logic [MEM_DATA_W-1:0] exp, act);
    if (ok) begin
      n_pass++;
    end else begin
      n_fail++;
      $display("FAIL %s: %s expected %0h actual %0h", cur_test, field, exp, act);
    end
  endtask

  task automatic report_problem(input string what);
    n_fail++;
    $display("ERROR %s: %s", cur_test, what);
  endtask

  task automatic check_wb(input logic exp_wen, input logic [4:0] exp_rd,
                          input logic [XLEN-1:0] exp_data);
    tally(out_rd_wen === exp_wen, "rd_wen", exp_wen, out_rd_wen);
    tally(out_rd_addr === exp_rd, "rd_addr", exp_rd, out_rd_addr);
    if (exp_wen) tally(out_rd_data === exp_data, "rd_data", exp_data, out_rd_data);
  endtask

  task automatic check_redirect(input logic exp_redirect, input logic [XLEN-1:0] exp_pc);
    tally(redirect === exp_redirect, "redirect", exp_redirect, redirect);
    if (exp_redirect) tally(redirect_pc === exp_pc, "redirect_pc", exp_pc, redirect_pc);
  endtask

  // out_ready with random low/high stretches in back-pressure mode
  always @(negedge clock) begin
    rng_mem = xorshift(rng_mem);
    mem_rnd = rng_mem;
    if (!bp_mode) begin
      out_ready = 1'b1;
    end else if (stretch != 3'd0) begin
      stretch = stretch - 3'd1;
    end else begin
      stretch   = rng_mem[11:9];
      out_ready = rng_mem[8];
    end
  end

  always @(posedge clock) begin : compare_outputs
    wb_exp_t e;
    if (reset) begin
      held = 1'b0;
    end else begin
      if (held && (!out_valid || held_snap !==
          {out_rd_wen, out_rd_addr, out_rd_data, redirect, redirect_pc}))
        report_problem("write-back outputs changed while out_ready was low");
      if (out_valid && !out_ready && in_ready)
        report_problem("in_ready high while write-back is stalled");
      if (exp_q.size() == 0 && busy_rd !== 5'd0)
        report_problem("busy_rd nonzero with no instruction in the stage");
      if (out_valid && exp_q.size() != 0 && busy_rd !== exp_q[0].rd)
        report_problem("busy_rd differs from the held destination");
      held      = out_valid && !out_ready;
      held_snap = {out_rd_wen, out_rd_addr, out_rd_data, redirect, redirect_pc};
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          report_problem("write-back with no instruction pending");
        end else begin
          e = exp_q.pop_front();
          check_wb(e.wen, e.rd, e.data);
          check_redirect(e.redirect, e.target);
        end
      end
    end
  end

  initial begin
    while (cycles <= 64 * n_issued + 200) begin
      @(posedge clock);
      cycles = cycles + 1;
    end
    $display("timeout after %0d cycles with %0d instructions issued", cycles, n_issued);
    $display("*** TEST FAILED ***");
    $finish;
  end

  task automatic issue(input logic [XLEN-1:0] pc, a, b, c, input logic use_pc,
                       input alu_op_t op, input logic alt, input logic [4:0] rd,
                       input logic rd_from_a, input ls_op_t ls, input branch_t br);
    wb_exp_t e;
    @(negedge clock);
    e = ref_exec(pc, a, b, c, use_pc, op, alt, rd, rd_from_a, ls, br);
    if (ls inside {ls_sb, ls_sh, ls_sw}) shadow_write(ls, alu_ref(pc, a, b, use_pc, alt, op), c);
    exp_q.push_back(e);
    n_issued++;
    in_valid     = 1'b1;
    in_pc        = pc;
    in_a         = a;
    in_b         = b;
    in_c         = c;
    in_use_pc    = use_pc;
    in_alu_op    = op;
    in_alu_alt   = alt;
    in_rd        = rd;
    in_rd_from_a = rd_from_a;
    in_ls_op     = ls;
    in_branch    = br;
    do @(posedge clock); while (!in_ready);
  endtask

  // address goes through the alu as base + offset
  task automatic issue_mem(input ls_op_t ls, input logic [XLEN-1:0] addr, data,
                           input logic [4:0] rd);
    issue(32'h1000, {addr[XLEN-1:3], 3'b000}, {29'b0, addr[2:0]}, data, 1'b0,
          alu_add, 1'b0, rd, 1'b0, ls, br_none);
  endtask

  task automatic random_mem_op(input logic store_only);
    logic [31:0]     r;
    logic [XLEN-1:0] data;
    logic [2:0]      off;
    ls_op_t          ls;
    r    = stim_rand();
    data = stim_rand();
    if (store_only || r[0]) ls = store_ops[r[2:1] % 3];
    else ls = load_ops[r[3:1] % 5];
    off = r[12:10] & ~3'(ls_bytes(ls) - 1); // natural alignment
    issue_mem(ls, {24'b0, r[8:4], off}, data, r[17:13]);
  endtask

  task automatic issue_alu_rand(input logic rd_zero);
    logic [31:0] r, pc, a, b, c;
    r  = stim_rand();
    pc = stim_rand();
    a  = stim_rand();
    b  = stim_rand();
    c  = stim_rand();
    issue(pc, a, b, c, r[0], alu_op_t'(r[3:1]), r[4], rd_zero ? 5'd0 : r[9:5],
          1'b0, ls_none, br_none);
  endtask

  task automatic issue_branch(input branch_t br);
    logic [31:0] r, pc, a, b, c;
    alu_op_t     op;
    r  = stim_rand();
    pc = stim_rand();
    a  = stim_rand();
    b  = r[0] ? a : stim_rand(); // equal operands give a zero result
    c  = stim_rand();
    if (r[1]) op = alu_xor;
    else op = alu_add; // sub with alt set
    issue(pc, a, b, c, 1'b0, op, 1'b1, r[6:2], br inside {br_jal, br_jalr}, ls_none, br);
  endtask

  task automatic drain();
    @(negedge clock);
    in_valid = 1'b0;
    while (exp_q.size() != 0) @(posedge clock);
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_issued = n_issued;
    test_fail   = n_fail;
  endtask

  task automatic finish_test();
    $display("test %-12s %3d instructions, %0d errors", cur_test,
             n_issued - test_issued, n_fail - test_fail);
  endtask

  task automatic check_reset_state();
    if ({out_valid, redirect, mem_ar_valid, mem_aw_valid, mem_w_valid,
         mem_r_ready, mem_b_ready} !== 7'b0)
      report_problem("a valid or response ready is high right after reset");
    else n_pass++;
    tally(in_ready === 1'b1, "in_ready", 1'b1, in_ready);
    tally(busy_rd === 5'd0, "busy_rd", 5'd0, busy_rd);
  endtask

  task automatic compare_memory();
    logic [MEM_DATA_W-1:0] w;
    for (int i = 0; i < 32; i++) begin
      for (int j = 0; j < 8; j++) w[8 * j +: 8] = shadow[8 * i + j];
      tally(u_mem.mem[i] === w, $sformatf("mem word %0d", i), w, u_mem.mem[i]);
    end
  endtask

  initial begin
    logic [2:0] off;
    ls_op_t     sop, lop;
    in_valid     = 1'b0;
    in_pc        = '0;
    in_a         = '0;
    in_b         = '0;
    in_c         = '0;
    in_use_pc    = 1'b0;
    in_alu_op    = alu_add;
    in_alu_alt   = 1'b0;
    in_rd        = '0;
    in_rd_from_a = 1'b0;
    in_ls_op     = ls_none;
    in_branch    = br_none;
    for (int i = 0; i < 256; i++) shadow[i] = 8'(i * 8'h9d + 8'h3b);

    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    @(posedge clock);
    start_test("reset");
    check_reset_state();
    finish_test();

    start_test("alu_random");
    for (int i = 0; i < 40; i++) issue_alu_rand(i % 5 == 0);
    drain();
    finish_test();

    start_test("load_store");
    for (int k = 0; k < 14; k++) begin
      if (k < 8) begin
        sop = ls_sb;
        off = 3'(k);
      end else if (k < 12) begin
        sop = ls_sh;
        off = 3'(2 * (k - 8));
      end else begin
        sop = ls_sw;
        off = 3'(4 * (k - 12));
      end
      issue_mem(sop, 8 * (k + 2) + off, stim_rand(), 5'(k + 1));
      for (int j = 0; j < 5; j++) begin
        lop = load_ops[j];
        issue_mem(lop, 8 * (k + 2) + (off & ~3'(ls_bytes(lop) - 1)), '0, 5'(k + j + 1));
      end
    end
    drain();
    finish_test();

    start_test("store_order");
    for (int i = 0; i < 24; i++) random_mem_op(1'b1);
    drain();
    finish_test();

    start_test("branch");
    for (int i = 0; i < 30; i++) issue_branch(branch_t'(i % 6));
    drain();
    finish_test();

    start_test("backpressure");
    bp_mode = 1'b1;
    for (int i = 0; i < 40; i++) begin
      if (stim_rand() & 32'h1) random_mem_op(1'b0);
      else issue_alu_rand(1'b0);
    end
    drain();
    bp_mode = 1'b0;
    finish_test();

    start_test("mem_image");
    compare_memory();
    finish_test();

    $display("checks passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: src.f
hdl/exu_pkg.sv
hdl/exu_alu.sv
hdl/exu_lsu.sv
hdl/exu_sequencer.sv
hdl/exu_top.sv
bench/exu_mem_model.sv
bench/exu_tb.sv
